/* all.f */
+incdir+test
src/router_pkg.sv
src/path_fifo.sv
src/packet_input_port.sv
src/packet_output_port.sv
src/packet_switch.sv
src/circuit_switch.sv
src/hybrid_router.sv
test/hybrid_router_tb.sv

/* test/hybrid_router_vectors.svh */
`ifndef HYBRID_ROUTER_VECTORS_SVH
`define HYBRID_ROUTER_VECTORS_SVH

// routing table for node 5 (x=1, y=1)
// columns: test name, input port, destination id, circuit data
// payload and expected port are filled in at the start of the run
localparam int NUM_VEC = 12;

string vec_name [NUM_VEC] = '{
  "local_to_east", "local_to_west", "local_to_north", "local_to_south",
  "local_to_self", "west_to_far_east", "east_to_west_row0", "north_to_south",
  "south_to_north", "east_to_local", "south_to_east", "north_to_local"
};

port_t vec_in [NUM_VEC] = '{L, L, L, L, L, W, E, N, S, E, S, N};

node_id_t vec_dest [NUM_VEC] = '{
  4'd6, 4'd4, 4'd1, 4'd9, 4'd5, 4'd15, 4'd0, 4'd13, 4'd1, 4'd5, 4'd11, 4'd5
};

cdata_t vec_cdata [NUM_VEC] = '{
  16'h1a2b, 16'h3c4d, 16'h5e6f, 16'h7081, 16'h92a3, 16'hb4c5,
  16'hd6e7, 16'hf809, 16'h0123, 16'h4567, 16'h89ab, 16'hcdef
};

// random payloads, expected output ports
payload_t vec_payload [NUM_VEC];
port_t    vec_exp [NUM_VEC];

// reference XY route
// x first, then y, else local
function automatic port_t xy_port(input node_id_t here, input node_id_t dest);
  int hx;
  int hy;
  int dx;
  int dy;
  hx = int'(here[1:0]);
  hy = int'(here[3:2]);
  dx = int'(dest[1:0]);
  dy = int'(dest[3:2]);
  if (dx > hx) return E;
  if (dx < hx) return W;
  // y grows towards the south
  if (dy > hy) return S;
  if (dy < hy) return N;
  return L;
endfunction

task automatic build_vectors();
  for (int t = 0; t < NUM_VEC; t++) begin
    vec_payload[t] = payload_t'($urandom());
    vec_exp[t]     = xy_port(NODE_ID, vec_dest[t]);
  end
endtask

`endif

/* test/hybrid_router_tb.sv */
module hybrid_router_tb;
  import router_pkg::*;

  localparam node_id_t NODE_ID = 4'd5;
  // cycles per wait loop
  localparam int TIMEOUT = 60;
  // cycles of silence after the last expected packet
  localparam int QUIET = 8;

  logic          clk;
  logic          rst;
  node_id_t      node_id;
  packet_link_t  packet_in [NUM_PORTS];
  logic [NUM_PORTS-1:0] full_in;
  packet_link_t  packet_out [NUM_PORTS];
  logic [NUM_PORTS-1:0] full_out;
  circuit_link_t circuit_in [NUM_PORTS];
  circuit_link_t circuit_out [NUM_PORTS];
  dir_t          ack_in;
  dir_t          ack_out;

  int error_count = 0;
  int test_errors_start = 0;
  int tests_run = 0;
  int tests_failed = 0;

  // delivered packets in arrival order
  port_t   seen_port [$];
  packet_t seen_pkt [$];

  `include "hybrid_router_vectors.svh"

  hybrid_router #(
    .PKT_DEPTH(4),
    .PATH_DEPTH(16)
  ) hybrid_router_inst (
    .clk(clk),
    .rst(rst),
    .node_id(node_id),
    .packet_in(packet_in),
    .full_in(full_in),
    .packet_out(packet_out),
    .full_out(full_out),
    .circuit_in(circuit_in),
    .circuit_out(circuit_out),
    .ack_in(ack_in),
    .ack_out(ack_out)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // a packet counts when it leaves at the next rising edge
  always @(negedge clk) begin
    if (!rst) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (packet_out[p].valid && !full_in[p]) begin
          seen_port.push_back(port_t'(p));
          seen_pkt.push_back(packet_out[p].packet);
        end
      end
    end
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_timeout(input string name, input string what);
    $display("timeout in %s: %s", name, what);
    error_count++;
  endtask

  function automatic dir_t to_dir(input port_t p);
    return dir_t'(1) << p;
  endfunction

  function automatic dir_t out_strobes();
    dir_t s;
    for (int p = 0; p < NUM_PORTS; p++) s[p] = circuit_out[p].strobe;
    return s;
  endfunction

  function automatic dir_t out_valids();
    dir_t v;
    for (int p = 0; p < NUM_PORTS; p++) v[p] = packet_out[p].valid;
    return v;
  endfunction

  // arrivals of one exact packet on one port
  function automatic int count_matches(input port_t p, input packet_t pk);
    int n;
    n = 0;
    for (int k = 0; k < seen_port.size(); k++) begin
      if (seen_port[k] == p && seen_pkt[k] == pk) n++;
    end
    return n;
  endfunction

  task automatic clear_inputs();
    for (int p = 0; p < NUM_PORTS; p++) begin
      packet_in[p]  = '0;
      circuit_in[p] = '0;
    end
    full_in = '0;
    ack_in  = '0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst = 1'b1;
    clear_inputs();
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
  endtask

  task automatic start_test();
    test_errors_start = error_count;
    seen_port.delete();
    seen_pkt.delete();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (error_count != test_errors_start) begin
      tests_failed++;
      $display("test %-28s errors", name);
    end else begin
      $display("test %-28s ok", name);
    end
  endtask

  // one-cycle valid, never into a full buffer
  task automatic send_packet(input string name, input port_t src,
                             input node_id_t dest, input payload_t pl);
    int cycles;
    cycles = 0;
    while (full_out[src] && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (full_out[src]) report_timeout(name, "input buffer stayed full");
    @(posedge clk);
    #1 packet_in[src] = '{valid: 1'b1, packet: '{dest: dest, payload: pl}};
    @(posedge clk);
    #1 packet_in[src] = '0;
  endtask

  task automatic wait_arrivals(input string name, input int n);
    int cycles;
    cycles = 0;
    while (seen_port.size() < n && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (seen_port.size() < n) begin
      report_timeout(name, $sformatf("%0d of %0d packets arrived", seen_port.size(), n));
    end
  endtask

  task automatic quiet_check(input string name, input int n);
    repeat (QUIET) @(posedge clk);
    check({name, " count"}, n, seen_port.size());
  endtask

  // strobe on src, expect it on dst one cycle later when hit is set
  task automatic send_word(input string name, input port_t src, input cdata_t data,
                           input logic last, input port_t dst, input logic hit);
    @(posedge clk);
    #1 circuit_in[src] = '{strobe: 1'b1, last: last, data: data};
    @(negedge clk);
    check({name, " early strobe"}, '0, out_strobes());
    @(posedge clk);
    #1 circuit_in[src] = '0;
    @(negedge clk);
    if (hit) begin
      check({name, " strobe"}, to_dir(dst), out_strobes());
      check({name, " data"}, data, circuit_out[dst].data);
      check({name, " last"}, last, circuit_out[dst].last);
    end else begin
      check({name, " dropped"}, '0, out_strobes());
    end
  endtask

  // ack on dst comes back on src only
  task automatic check_ack(input string name, input port_t src, input port_t dst);
    @(posedge clk);
    #1 ack_in = to_dir(dst);
    @(negedge clk);
    check({name, " ack"}, to_dir(src), ack_out);
    @(posedge clk);
    #1 ack_in = '0;
  endtask

  initial begin
    string   name;
    packet_t pk_a;
    packet_t pk_b;
    int      cycles;

    rst     = 1'b1;
    node_id = NODE_ID;
    clear_inputs();
    void'($urandom(8));
    build_vectors();
    apply_reset();

    // idle outputs after reset, early strobe goes nowhere
    // every ack raised, but no input has a path to return it on
    start_test();
    ack_in = '1;
    @(negedge clk);
    check("reset valid", '0, out_valids());
    check("reset strobe", '0, out_strobes());
    check("reset full_out", '0, full_out);
    check("reset ack", '0, ack_out);
    @(posedge clk);
    #1 ack_in = '0;
    send_word("early strobe", W, 16'h1234, 1'b0, W, 1'b0);
    end_test("reset_state");

    for (int t = 0; t < NUM_VEC; t++) begin
      name = vec_name[t];
      start_test();
      send_packet(name, vec_in[t], vec_dest[t], vec_payload[t]);
      wait_arrivals(name, 1);
      if (seen_port.size() > 0) begin
        check({name, " port"}, vec_exp[t], seen_port[0]);
        check({name, " dest"}, vec_dest[t], seen_pkt[0].dest);
        check({name, " payload"}, vec_payload[t], seen_pkt[0].payload);
      end
      quiet_check(name, 1);
      end_test({"route ", name});

      // circuit along the reserved path, torn down by the last word
      start_test();
      check_ack(name, vec_in[t], vec_exp[t]);
      send_word({name, " word"}, vec_in[t], vec_cdata[t], 1'b0, vec_exp[t], 1'b1);
      send_word({name, " last"}, vec_in[t], ~vec_cdata[t], 1'b1, vec_exp[t], 1'b1);
      send_word({name, " after"}, vec_in[t], vec_cdata[t], 1'b0, vec_exp[t], 1'b0);
      end_test({"circuit ", name});
    end

    // east held full, packet waits in the output register
    apply_reset();
    start_test();
    pk_a = '{dest: 4'd6, payload: payload_t'($urandom())};
    @(posedge clk);
    #1 full_in[E] = 1'b1;
    send_packet("backpressure", L, pk_a.dest, pk_a.payload);
    cycles = 0;
    @(negedge clk);
    while (!packet_out[E].valid && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!packet_out[E].valid) report_timeout("backpressure", "no valid on east");
    repeat (4) begin
      @(negedge clk);
      check("backpressure valid", 1'b1, packet_out[E].valid);
      check("backpressure hold", pk_a, packet_out[E].packet);
    end
    check("backpressure early", 0, seen_port.size());
    @(posedge clk);
    #1 full_in[E] = 1'b0;
    wait_arrivals("backpressure", 1);
    check("backpressure packet", 1, count_matches(E, pk_a));
    quiet_check("backpressure", 1);
    end_test("backpressure");

    // west and north both head east in the same cycle
    apply_reset();
    start_test();
    pk_a = '{dest: 4'd7, payload: payload_t'($urandom())};
    pk_b = '{dest: 4'd6, payload: payload_t'($urandom())};
    @(posedge clk);
    #1;
    packet_in[W] = '{valid: 1'b1, packet: pk_a};
    packet_in[N] = '{valid: 1'b1, packet: pk_b};
    @(posedge clk);
    #1;
    packet_in[W] = '0;
    packet_in[N] = '0;
    wait_arrivals("contention", 2);
    check("contention west packet", 1, count_matches(E, pk_a));
    check("contention north packet", 1, count_matches(E, pk_b));
    quiet_check("contention", 2);
    end_test("contention");

    // two paths queued on local, used and torn down in order
    apply_reset();
    start_test();
    send_packet("teardown", L, 4'd6, payload_t'($urandom()));
    send_packet("teardown", L, 4'd4, payload_t'($urandom()));
    wait_arrivals("teardown", 2);
    send_word("teardown first", L, 16'hca11, 1'b1, E, 1'b1);
    send_word("teardown second", L, 16'hbe57, 1'b1, W, 1'b1);
    send_word("teardown empty", L, 16'h0dd5, 1'b0, W, 1'b0);
    end_test("teardown_queue");

    $display("tests run %0d, tests with errors %0d, check errors %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* src/hybrid_router.sv */
module hybrid_router #(
  parameter int PKT_DEPTH  = 4,
  parameter int PATH_DEPTH = 16
) (
  input  logic                             clk,
  input  logic                             rst,
  input  router_pkg::node_id_t             node_id,
  // packet side
  input  router_pkg::packet_link_t         packet_in [router_pkg::NUM_PORTS],
  input  logic [router_pkg::NUM_PORTS-1:0] full_in,
  output router_pkg::packet_link_t         packet_out [router_pkg::NUM_PORTS],
  output logic [router_pkg::NUM_PORTS-1:0] full_out,
  // circuit side
  input  router_pkg::circuit_link_t        circuit_in [router_pkg::NUM_PORTS],
  output router_pkg::circuit_link_t        circuit_out [router_pkg::NUM_PORTS],
  input  router_pkg::dir_t                 ack_in,
  output router_pkg::dir_t                 ack_out
);
  import router_pkg::*;

  // input path FIFOs, one per input, hold the chosen output
  dir_t in_record;
  dir_t in_record_dir [NUM_PORTS];
  dir_t in_head [NUM_PORTS];
  dir_t in_empty;
  dir_t in_path_full;
  dir_t in_pop;
  // output path FIFOs, one per output, hold the source input
  dir_t out_record;
  dir_t out_record_dir [NUM_PORTS];
  dir_t out_head [NUM_PORTS];
  dir_t out_empty;
  dir_t out_path_full;
  dir_t out_pop;

  packet_switch #(
    .PKT_DEPTH(PKT_DEPTH)
  ) packet_switch_inst (
    .clk(clk),
    .rst(rst),
    .node_id(node_id),
    .packet_in(packet_in),
    .full_in(full_in),
    .packet_out(packet_out),
    .full_out(full_out),
    .in_path_full(in_path_full),
    .out_path_full(out_path_full),
    .in_record(in_record),
    .out_record(out_record),
    .in_record_dir(in_record_dir),
    .out_record_dir(out_record_dir)
  );

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_path
    path_fifo #(
      .DEPTH(PATH_DEPTH)
    ) in_path_fifo_inst (
      .clk(clk),
      .rst(rst),
      .push(in_record[p]),
      .push_dir(in_record_dir[p]),
      .pop(in_pop[p]),
      .head(in_head[p]),
      .empty(in_empty[p]),
      .full(in_path_full[p])
    );

    path_fifo #(
      .DEPTH(PATH_DEPTH)
    ) out_path_fifo_inst (
      .clk(clk),
      .rst(rst),
      .push(out_record[p]),
      .push_dir(out_record_dir[p]),
      .pop(out_pop[p]),
      .head(out_head[p]),
      .empty(out_empty[p]),
      .full(out_path_full[p])
    );
  end

  circuit_switch circuit_switch_inst (
    .clk(clk),
    .rst(rst),
    .circuit_in(circuit_in),
    .circuit_out(circuit_out),
    .ack_in(ack_in),
    .ack_out(ack_out),
    .in_head(in_head),
    .out_head(out_head),
    .in_empty(in_empty),
    .out_empty(out_empty),
    .in_pop(in_pop),
    .out_pop(out_pop)
  );

endmodule

/* src/circuit_switch.sv */
module circuit_switch (
  input  logic                      clk,
  input  logic                      rst,
  input  router_pkg::circuit_link_t circuit_in [router_pkg::NUM_PORTS],
  output router_pkg::circuit_link_t circuit_out [router_pkg::NUM_PORTS],
  input  router_pkg::dir_t          ack_in,
  output router_pkg::dir_t          ack_out,
  input  router_pkg::dir_t          in_head [router_pkg::NUM_PORTS],
  input  router_pkg::dir_t          out_head [router_pkg::NUM_PORTS],
  input  router_pkg::dir_t          in_empty,
  input  router_pkg::dir_t          out_empty,
  output router_pkg::dir_t          in_pop,
  output router_pkg::dir_t          out_pop
);
  import router_pkg::*;

  // route[i], output named by a live strobe on input i
  dir_t                 route [NUM_PORTS];
  // arrive[o][i], live strobe from i heading to o
  dir_t                 arrive [NUM_PORTS];
  // word picked by each output mux
  circuit_link_t        sel_link [NUM_PORTS];
  logic [NUM_PORTS-1:0] fwd;
  logic [NUM_PORTS-1:0] last_in;
  logic [NUM_PORTS-1:0] out_strobe;
  logic [NUM_PORTS-1:0] out_last;
  cdata_t               out_data [NUM_PORTS];

  // strobe on an input with no recorded path is dropped
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      route[i]   = (circuit_in[i].strobe && !in_empty[i]) ? in_head[i] : '0;
      last_in[i] = circuit_in[i].last;
    end
  end

  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        arrive[o][i] = route[i][o];
      end
    end
  end

  // output mux follows the output path head
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      sel_link[o] = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (out_head[o][i]) sel_link[o] = circuit_in[i];
      end
      // both ends of the path have to agree
      fwd[o] = !out_empty[o] && |(arrive[o] & out_head[o]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_strobe <= '0;
    end else begin
      out_strobe <= fwd;
    end
  end

  // word and last flag, one cycle behind the input
  always_ff @(posedge clk) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      out_last[o] <= sel_link[o].last;
      out_data[o] <= sel_link[o].data;
    end
  end

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_out
    assign circuit_out[p] = '{strobe: out_strobe[p], last: out_last[p], data: out_data[p]};
  end

  // ack goes back along the input's current path
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      ack_out[i] = !in_empty[i] && |(ack_in & in_head[i]);
    end
  end

  // teardown, last word pops both ends on the same edge
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      in_pop[i] = |route[i] && last_in[i];
    end
    for (int o = 0; o < NUM_PORTS; o++) begin
      out_pop[o] = |(arrive[o] & last_in);
    end
  end

endmodule

/* src/packet_switch.sv */
module packet_switch #(
  parameter int PKT_DEPTH = 4
) (
  input  logic                              clk,
  input  logic                              rst,
  input  router_pkg::node_id_t              node_id,
  input  router_pkg::packet_link_t          packet_in [router_pkg::NUM_PORTS],
  input  logic [router_pkg::NUM_PORTS-1:0]  full_in,
  output router_pkg::packet_link_t          packet_out [router_pkg::NUM_PORTS],
  output logic [router_pkg::NUM_PORTS-1:0]  full_out,
  input  router_pkg::dir_t                  in_path_full,
  input  router_pkg::dir_t                  out_path_full,
  output router_pkg::dir_t                  in_record,
  output router_pkg::dir_t                  out_record,
  output router_pkg::dir_t                  in_record_dir [router_pkg::NUM_PORTS],
  output router_pkg::dir_t                  out_record_dir [router_pkg::NUM_PORTS]
);
  import router_pkg::*;

  packet_t              head [NUM_PORTS];
  dir_t                 head_dir [NUM_PORTS];
  logic [NUM_PORTS-1:0] head_valid;
  // requests[o][i], input i wants output o
  dir_t                 requests [NUM_PORTS];
  // grant[o][i], one hot per output
  dir_t                 grant [NUM_PORTS];
  logic [NUM_PORTS-1:0] pop;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    packet_input_port #(
      .DEPTH(PKT_DEPTH)
    ) input_port_inst (
      .clk(clk),
      .rst(rst),
      .node_id(node_id),
      .link_in(packet_in[p]),
      .full(full_out[p]),
      .pop(pop[p]),
      .head(head[p]),
      .head_dir(head_dir[p]),
      .head_valid(head_valid[p])
    );

    // output side also needs room in its own path FIFO
    packet_output_port output_port_inst (
      .clk(clk),
      .rst(rst),
      .requests(requests[p]),
      .path_ready(!out_path_full[p]),
      .full_in(full_in[p]),
      .candidates(head),
      .grant(grant[p]),
      .link_out(packet_out[p])
    );

    // output record names the source input
    assign out_record[p]     = |grant[p];
    assign out_record_dir[p] = grant[p];
    // input record names the chosen output
    assign in_record_dir[p]  = head_dir[p];
  end

  // transpose head directions into per-output requests
  // inputs whose path FIFO is full stay out
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        requests[o][i] = head_valid[i] && head_dir[i][o] && !in_path_full[i];
      end
    end
  end

  // an input heads for one output only, so at most one grant per input
  always_comb begin
    pop = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      pop = pop | grant[o];
    end
  end

  assign in_record = pop;

endmodule

/* src/packet_output_port.sv */
module packet_output_port (
  input  logic                     clk,
  input  logic                     rst,
  input  router_pkg::dir_t         requests,
  input  logic                     path_ready,
  input  logic                     full_in,
  input  router_pkg::packet_t      candidates [router_pkg::NUM_PORTS],
  output router_pkg::dir_t         grant,
  output router_pkg::packet_link_t link_out
);
  import router_pkg::*;

  // highest priority requester this cycle
  port_t      rr_ptr;
  logic [2:0] sel;
  logic       any_req;
  logic       can_load;
  logic       do_grant;
  logic       out_valid;
  packet_t    out_packet;

  // round-robin search starting at rr_ptr
  always_comb begin
    int idx;
    any_req = 1'b0;
    sel     = '0;
    for (int k = 0; k < NUM_PORTS; k++) begin
      idx = (int'(rr_ptr) + k) % NUM_PORTS;
      if (!any_req && requests[idx]) begin
        any_req = 1'b1;
        sel     = 3'(idx);
      end
    end
  end

  // register empty, or its packet leaves at this edge
  assign can_load = !out_valid || !full_in;
  // path record needs room on both sides
  assign do_grant = can_load && path_ready && any_req;

  always_comb begin
    grant = '0;
    if (do_grant) grant[sel] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      rr_ptr    <= S;
    end else begin
      // hold under full_in, else load or go idle
      if (can_load) out_valid <= do_grant;
      // winner gets lowest priority next round
      if (do_grant) begin
        rr_ptr <= (sel == 3'(NUM_PORTS - 1)) ? S : port_t'(sel + 3'd1);
      end
    end
  end

  // payload only changes on a grant
  always_ff @(posedge clk) begin
    if (do_grant) out_packet <= candidates[sel];
  end

  assign link_out = '{valid: out_valid, packet: out_packet};

endmodule

/* src/packet_input_port.sv */
module packet_input_port #(
  parameter int DEPTH = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  input  router_pkg::node_id_t     node_id,
  input  router_pkg::packet_link_t link_in,
  output logic                     full,
  input  logic                     pop,
  output router_pkg::packet_t      head,
  output router_pkg::dir_t         head_dir,
  output logic                     head_valid
);
  import router_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  packet_t       buffer [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          wr_en;
  logic          rd_en;
  logic [1:0]    my_x;
  logic [1:0]    my_y;
  logic [1:0]    dst_x;
  logic [1:0]    dst_y;

  function automatic logic [AW-1:0] bump(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // a valid that lands while full is lost
  assign wr_en = link_in.valid && !full;
  assign rd_en = pop && head_valid;

  assign full       = (count == (AW + 1)'(DEPTH));
  assign head_valid = (count != '0);
  assign head       = buffer[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= bump(wr_ptr);
      if (rd_en) rd_ptr <= bump(rd_ptr);
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) buffer[wr_ptr] <= link_in.packet;
  end

  // own and target coordinates
  assign my_x  = node_id[1:0];
  assign my_y  = node_id[3:2];
  assign dst_x = head.dest[1:0];
  assign dst_y = head.dest[3:2];

  // XY routing, x first, then y, else local
  always_comb begin
    head_dir = '0;
    if (dst_x > my_x) begin
      head_dir[E] = 1'b1;
    end else if (dst_x < my_x) begin
      head_dir[W] = 1'b1;
    end else if (dst_y > my_y) begin
      head_dir[S] = 1'b1;
    end else if (dst_y < my_y) begin
      head_dir[N] = 1'b1;
    end else begin
      head_dir[L] = 1'b1;
    end
  end

endmodule

/* src/path_fifo.sv */
module path_fifo #(
  parameter int DEPTH = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             push,
  input  router_pkg::dir_t push_dir,
  input  logic             pop,
  output router_pkg::dir_t head,
  output logic             empty,
  output logic             full
);
  import router_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  dir_t          mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_push;
  logic          do_pop;

  // wrap at DEPTH, works for any depth
  function automatic logic [AW-1:0] bump(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // push when full and pop when empty are ignored
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty = (count == '0);
  assign full  = (count == (AW + 1)'(DEPTH));
  // oldest recorded direction
  assign head  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= bump(wr_ptr);
      if (do_pop) rd_ptr <= bump(rd_ptr);
      // count moves only on one-sided traffic
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // path storage
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_dir;
  end

endmodule

/* src/router_pkg.sv */
package router_pkg;

  // five router ports
  localparam int NUM_PORTS = 5;

  // port index order S, E, N, W, L
  typedef enum logic [2:0] {
    S = 3'd0,
    E = 3'd1,
    N = 3'd2,
    W = 3'd3,
    L = 3'd4
  } port_t;

  // one-hot direction, bit position is the port_t value
  // all zero means no direction
  typedef logic [NUM_PORTS-1:0] dir_t;

  // node id on a 4x4 mesh, x in [1:0], y in [3:2]
  typedef logic [3:0] node_id_t;

  // setup packet payload
  typedef logic [11:0] payload_t;

  // single-flit setup packet, destination in the top bits
  typedef struct packed {
    node_id_t dest;
    payload_t payload;
  } packet_t;

  // packet link, sender side of valid/full
  typedef struct packed {
    logic    valid;
    packet_t packet;
  } packet_link_t;

  // circuit data word
  typedef logic [15:0] cdata_t;

  // circuit link
  // strobe marks a word, last tears the path down
  typedef struct packed {
    logic   strobe;
    logic   last;
    cdata_t data;
  } circuit_link_t;

endpackage
